// ==== Makefile ====
TOP := tb_mem_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module mem_subsys_top

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== list.f ====
+incdir+verilog
verilog/mem_pkg.sv
verilog/cache_mem_if.sv
verilog/mem_delay_line.sv
verilog/icache.sv
verilog/dcache.sv
verilog/inst_rom.sv
verilog/data_ram.sv
verilog/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// ==== sim/mem_tests.txt ====
# op name addr strb data expected (hex), ops if ifu iff rd rdu wr wru
# sync starts a new segment, where fetch and load/store tests run side by side
if   ic_miss         00000004 0 00000000 959a89bc
if   ic_hit          00000008 0 00000000 37c3036f
if   ic_other_line   00000020 0 00000000 fa163d85
ifu  ic_uncached     0000000c 0 00000000 d10b9d1e
ifu  ic_uncached_far 00000040 0 00000000 e8da6b1d
iff  ic_flushed      00000040 0 00000000 00000000
if   ic_after_flush  00000040 0 00000000 e8da6b1d
sync -               00000000 0 00000000 00000000
rd   dc_fresh        00000100 0 00000000 00000000
wr   dc_wr_lo        00000100 3 11223344 00000000
wru  dc_wru_hi       00000100 8 aabbccdd 00000000
wr   dc_wr_b2        00000100 4 00550000 00000000
rd   dc_merged       00000100 0 00000000 aa553344
rdu  dc_merged_u     00000100 0 00000000 aa553344
wr   dc_wr_miss      00000200 f deadbeef 00000000
wru  dc_wru_miss     00000200 1 00000042 00000000
rd   dc_miss_merge   00000200 0 00000000 deadbe42
rd   dc_hold         00000344 0 00000000 00000000
wr   dc_wt           00000348 f 12345678 00000000
rd   dc_wt_hit       00000348 0 00000000 12345678
rdu  dc_wt_ram       00000348 0 00000000 12345678
sync -               00000000 0 00000000 00000000
if   par_if_a        00000004 0 00000000 959a89bc
wr   par_wr          000003f0 f cafef00d 00000000
ifu  par_ifu_a       00000008 0 00000000 37c3036f
rd   par_rd          000003f0 0 00000000 cafef00d
if   par_if_b        00000010 0 00000000 737016c9
wru  par_wru         000003f4 6 00abcd00 00000000
ifu  par_ifu_b       0000000c 0 00000000 d10b9d1e
rdu  par_rdu         000003f4 0 00000000 00abcd00
rd   par_rd_hit      000003f4 0 00000000 00abcd00

// ==== sim/tb_mem_subsys.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int WAIT_MAX = `MEM_LATENCY + 6;

    logic       clk;
    logic       reset_i;
    logic       fetch_req_i;
    bus32_t     fetch_addr_i;
    logic       fetch_uncache_i;
    logic       flush_i;
    logic       fetch_ready_o;
    logic       fetch_valid_o;
    bus32_t     fetch_inst_o;
    logic       lsu_req_i;
    logic       lsu_we_i;
    logic       lsu_uncache_i;
    bus32_t     lsu_addr_i;
    logic [3:0] lsu_strb_i;
    bus32_t     lsu_wdata_i;
    logic       lsu_ready_o;
    logic       lsu_valid_o;
    bus32_t     lsu_rdata_o;

    // one entry per test line
    string      t_op   [$];
    string      t_name [$];
    bus32_t     t_addr [$];
    logic [3:0] t_strb [$];
    bus32_t     t_data [$];
    bus32_t     t_exp  [$];
    int         t_seg  [$];

    // lines each cache should hold, row 0 fetch and row 1 load/store
    bit         held      [2][`CACHE_LINES];
    bus32_t     held_line [2][`CACHE_LINES];

    int cycles = 0;
    int cycle_limit = 0;
    int value_errs = 0;
    int latency_errs = 0;
    int missing_errs = 0;
    int unexpected_errs = 0;
    int fetch_seen = 0;
    int fetch_taken = 0;
    int lsu_seen = 0;
    int lsu_taken = 0;

    mem_subsys_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // every answer pulse, requested or not
    always @(negedge clk) begin
        if (!reset_i && fetch_valid_o) begin
            fetch_seen++;
        end
        if (!reset_i && lsu_valid_o) begin
            lsu_seen++;
        end
    end

    function automatic bit is_fetch_op(input string op);
        return op == "if" || op == "ifu" || op == "iff";
    endfunction

    task automatic load_tests(output bit ok, output int n_segs);
        int         fd;
        int         n;
        string      line;
        string      op;
        string      name;
        bus32_t     addr;
        logic [3:0] strb;
        bus32_t     data;
        bus32_t     expv;
        ok = 1'b0;
        n_segs = 0;
        fd = $fopen("sim/mem_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %s %h %h %h %h", op, name, addr, strb, data, expv);
                if (n != 6) begin
                    continue;
                end
                if (op == "sync") begin
                    n_segs++;
                    continue;
                end
                t_op.push_back(op);
                t_name.push_back(name);
                t_addr.push_back(addr);
                t_strb.push_back(strb);
                t_data.push_back(data);
                t_exp.push_back(expv);
                t_seg.push_back(n_segs);
            end
            $fclose(fd);
        end
    endtask

    // cached reads hit on a held line and otherwise refill it
    task automatic predict_latency(input bit is_fetch, input int i, output int lat);
        bus32_t line_no;
        int     set;
        int     port;
        line_no = t_addr[i] / (`LINE_WORDS * 4);
        set     = int'(line_no % `CACHE_LINES);
        port    = is_fetch ? 0 : 1;
        if (t_op[i] == "if" || t_op[i] == "iff" || t_op[i] == "rd") begin
            if (held[port][set] && held_line[port][set] == line_no) begin
                lat = 1;
            end else begin
                lat = `MEM_LATENCY + 2;
                held[port][set]      = 1'b1;
                held_line[port][set] = line_no;
            end
        end else begin
            lat = `MEM_LATENCY + 1;
        end
    endtask

    // wait at falling edges until the answer shows up or the wait runs out
    task automatic wait_answer(input bit is_fetch, output bit seen, output int lat);
        int waited;
        waited = 0;
        @(negedge clk);
        seen = is_fetch ? fetch_valid_o : lsu_valid_o;
        while (!seen && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
            seen = is_fetch ? fetch_valid_o : lsu_valid_o;
        end
        lat = waited + 1;
    endtask

    task automatic run_fetch(input int i);
        bit seen;
        int lat;
        int exp_lat;
        predict_latency(1'b1, i, exp_lat);
        @(negedge clk);
        while (!fetch_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        fetch_req_i     <= 1'b1;
        fetch_addr_i    <= t_addr[i];
        fetch_uncache_i <= (t_op[i] == "ifu");
        @(posedge clk);
        fetch_req_i <= 1'b0;
        if (t_op[i] == "iff") begin
            // flush during the cycle after acceptance
            flush_i <= 1'b1;
            for (int c = 0; c < `MEM_LATENCY + 4; c++) begin
                @(negedge clk);
                if (fetch_valid_o) begin
                    $display("%s: fetch answered although it was flushed", t_name[i]);
                    unexpected_errs++;
                    fetch_taken++;
                end
                if (c == 0) begin
                    @(posedge clk);
                    flush_i <= 1'b0;
                end
            end
        end else begin
            wait_answer(1'b1, seen, lat);
            if (!seen) begin
                $display("%s: no fetch answer within %0d cycles", t_name[i], WAIT_MAX);
                missing_errs++;
            end else begin
                fetch_taken++;
                if (fetch_inst_o !== t_exp[i]) begin
                    $display("ERROR %s: expected %h, got %h", t_name[i], t_exp[i], fetch_inst_o);
                    value_errs++;
                end
                if (lat != exp_lat) begin
                    $display("ERROR %s: expected latency %0d, got %0d",
                             t_name[i], exp_lat, lat);
                    latency_errs++;
                end
            end
        end
    endtask

    task automatic run_lsu(input int i);
        bit seen;
        bit is_wr;
        int lat;
        int exp_lat;
        is_wr = (t_op[i] == "wr") || (t_op[i] == "wru");
        predict_latency(1'b0, i, exp_lat);
        @(negedge clk);
        while (!lsu_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        lsu_req_i     <= 1'b1;
        lsu_we_i      <= is_wr;
        lsu_uncache_i <= (t_op[i] == "rdu") || (t_op[i] == "wru");
        lsu_addr_i    <= t_addr[i];
        lsu_strb_i    <= t_strb[i];
        lsu_wdata_i   <= t_data[i];
        @(posedge clk);
        lsu_req_i <= 1'b0;
        wait_answer(1'b0, seen, lat);
        if (!seen) begin
            $display("%s: no load/store answer within %0d cycles", t_name[i], WAIT_MAX);
            missing_errs++;
        end else begin
            lsu_taken++;
            if (!is_wr && lsu_rdata_o !== t_exp[i]) begin
                $display("ERROR %s: expected %h, got %h", t_name[i], t_exp[i], lsu_rdata_o);
                value_errs++;
            end
            if (lat != exp_lat) begin
                $display("ERROR %s: expected latency %0d, got %0d",
                         t_name[i], exp_lat, lat);
                latency_errs++;
            end
        end
    endtask

    task automatic fetch_segment(input int s);
        for (int i = 0; i < t_op.size(); i++) begin
            if (t_seg[i] == s && is_fetch_op(t_op[i])) begin
                run_fetch(i);
            end
        end
    endtask

    task automatic lsu_segment(input int s);
        for (int i = 0; i < t_op.size(); i++) begin
            if (t_seg[i] == s && !is_fetch_op(t_op[i])) begin
                run_lsu(i);
            end
        end
    endtask

    initial begin
        bit ok;
        int n_segs;
        reset_i         = 1'b1;
        fetch_req_i     = 1'b0;
        fetch_addr_i    = '0;
        fetch_uncache_i = 1'b0;
        flush_i         = 1'b0;
        lsu_req_i       = 1'b0;
        lsu_we_i        = 1'b0;
        lsu_uncache_i   = 1'b0;
        lsu_addr_i      = '0;
        lsu_strb_i      = '0;
        lsu_wdata_i     = '0;
        load_tests(ok, n_segs);
        if (!ok) begin
            $display("could not open sim/mem_tests.txt");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = t_op.size() * (`MEM_LATENCY + 8) + 50;
            repeat (3) @(posedge clk);
            reset_i <= 1'b0;
            @(negedge clk);
            if (!fetch_ready_o || !lsu_ready_o) begin
                $display("ready outputs are not high after reset");
                unexpected_errs++;
            end
            // both ports run side by side within a segment
            for (int s = 0; s <= n_segs; s++) begin
                fork
                    fetch_segment(s);
                    lsu_segment(s);
                join
            end
            repeat (4) @(negedge clk);
            if (fetch_seen != fetch_taken || lsu_seen != lsu_taken) begin
                $display("unexpected answers: %0d on fetch, %0d on load/store",
                         fetch_seen - fetch_taken, lsu_seen - lsu_taken);
                unexpected_errs++;
            end
            $display("%0d tests, errors: value %0d, latency %0d, missing %0d, unexpected %0d",
                     t_op.size(), value_errs, latency_errs, missing_errs, unexpected_errs);
            if (value_errs + latency_errs + missing_errs + unexpected_errs == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== verilog/cache_mem_if.sv ====
`timescale 1ns/1ns

interface cache_mem_if;
    import mem_pkg::*;

    // line refill
    logic       rd_req;
    bus32_t     rd_addr;
    logic       ret_valid;
    bus256_t    ret_data;

    // uncached word read
    logic       ucache_ren;
    bus32_t     ucache_addr;
    logic       ucache_rvalid;
    bus32_t     ucache_rdata;

    // word write
    logic       wr_en;
    bus32_t     wr_addr;
    logic [3:0] wr_strb;
    bus32_t     wr_data;
    logic       wr_ack;

    modport cache (
        output rd_req, rd_addr, ucache_ren, ucache_addr,
        output wr_en, wr_addr, wr_strb, wr_data,
        input  ret_valid, ret_data, ucache_rvalid, ucache_rdata, wr_ack
    );

    modport mem (
        input  rd_req, rd_addr, ucache_ren, ucache_addr,
        input  wr_en, wr_addr, wr_strb, wr_data,
        output ret_valid, ret_data, ucache_rvalid, ucache_rdata, wr_ack
    );

endinterface

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module data_ram (
    input  logic     clk,
    input  logic     reset_i,
    cache_mem_if.mem mem
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);

    bus32_t           ram_q [`MEM_WORDS];
    bus256_t          line_data;
    bus32_t           word_data;
    logic [IDX_W-1:0] line_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             ack_valid;

    assign line_idx = mem.rd_addr[2 +: IDX_W];
    assign rd_idx   = mem.ucache_addr[2 +: IDX_W];
    assign wr_idx   = mem.wr_addr[2 +: IDX_W];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                ram_q[i] <= '0;
            end
        end else if (mem.wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (mem.wr_strb[b]) begin
                    ram_q[wr_idx][b*8 +: 8] <= mem.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // sampled at request time
    always_comb begin
        for (int k = 0; k < `LINE_WORDS; k++) begin
            line_data[k*32 +: 32] = ram_q[line_idx + IDX_W'(k)];
        end
    end

    assign word_data = ram_q[rd_idx];

    mem_delay_line #(
        .payload_t (bus256_t),
        .DEPTH     (`MEM_LATENCY)
    ) u_line_dl (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (mem.rd_req),
        .in_data_i   (line_data),
        .out_valid_o (mem.ret_valid),
        .out_data_o  (mem.ret_data)
    );

    mem_delay_line #(
        .payload_t (bus32_t),
        .DEPTH     (`MEM_LATENCY)
    ) u_word_dl (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (mem.ucache_ren),
        .in_data_i   (word_data),
        .out_valid_o (mem.ucache_rvalid),
        .out_data_o  (mem.ucache_rdata)
    );

    // the ack is the valid of the one-bit line
    mem_delay_line #(
        .payload_t (logic),
        .DEPTH     (`MEM_LATENCY)
    ) u_ack_dl (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (mem.wr_en),
        .in_data_i   (1'b1),
        .out_valid_o (ack_valid),
        .out_data_o  ()
    );

    assign mem.wr_ack = ack_valid;

endmodule

// ==== verilog/dcache.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module dcache (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              lsu_req_i,
    input  mem_pkg::lsu_req_t lsu_req_data_i,
    output logic              lsu_ready_o,
    output logic              lsu_valid_o,
    output mem_pkg::bus32_t   lsu_rdata_o,
    cache_mem_if.cache        mem
);
    import mem_pkg::*;

    localparam int OFF_W  = $clog2(`LINE_WORDS * 4);
    localparam int WOFF_W = $clog2(`LINE_WORDS);
    localparam int IDX_W  = $clog2(`CACHE_LINES);
    localparam int TAG_W  = `ADDR_W - IDX_W - OFF_W;

    typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_REFILL, S_WORD} state_e;

    state_e            state_q;
    state_e            state_d;
    lsu_req_t          req_q;
    logic              accept;
    logic              hit;
    logic              cached_rd;
    logic              word_done;
    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [WOFF_W-1:0] woff;
    bus256_t           cur_line;
    bus32_t            cur_word;
    bus32_t            merged;

    logic [TAG_W-1:0]        tag_q  [`CACHE_LINES];
    bus256_t                 line_q [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;

    assign accept    = lsu_req_i && lsu_ready_o;
    assign idx       = req_q.addr[OFF_W +: IDX_W];
    assign tag       = req_q.addr[`ADDR_W-1 -: TAG_W];
    assign woff      = req_q.addr[2 +: WOFF_W];
    assign cur_line  = line_q[idx];
    assign cur_word  = cur_line[woff*32 +: 32];
    assign hit       = valid_q[idx] && (tag_q[idx] == tag);
    assign cached_rd = !req_q.we && !req_q.uncache;
    assign word_done = req_q.we ? mem.wr_ack : mem.ucache_rvalid;

    // strobed bytes over the cached word
    always_comb begin
        merged = cur_word;
        for (int b = 0; b < 4; b++) begin
            if (req_q.strb[b]) begin
                merged[b*8 +: 8] = req_q.wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (accept) state_d = S_LOOKUP;
            S_LOOKUP: begin
                if (!cached_rd) begin
                    state_d = S_WORD;
                end else if (hit) begin
                    state_d = S_IDLE;
                end else begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: if (mem.ret_valid) state_d = S_LOOKUP;
            S_WORD:   if (word_done) state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= lsu_req_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (state_q == S_REFILL && mem.ret_valid) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_REFILL && mem.ret_valid) begin
            line_q[idx] <= mem.ret_data;
            tag_q[idx]  <= tag;
        end else if (state_q == S_LOOKUP && req_q.we && hit) begin
            // uncached writes update a held line too, keeps it coherent with ram
            line_q[idx][woff*32 +: 32] <= merged;
        end
    end

    assign lsu_ready_o = (state_q == S_IDLE);
    assign lsu_valid_o = (state_q == S_LOOKUP && cached_rd && hit) ||
                         (state_q == S_WORD && word_done);
    assign lsu_rdata_o = (state_q == S_WORD) ? mem.ucache_rdata : cur_word;

    assign mem.rd_req      = (state_q == S_LOOKUP) && cached_rd && !hit;
    assign mem.rd_addr     = {req_q.addr[`ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign mem.ucache_ren  = (state_q == S_LOOKUP) && !req_q.we && req_q.uncache;
    assign mem.ucache_addr = req_q.addr;

    // every write goes through to ram
    assign mem.wr_en   = (state_q == S_LOOKUP) && req_q.we;
    assign mem.wr_addr = req_q.addr;
    assign mem.wr_strb = req_q.strb;
    assign mem.wr_data = req_q.wdata;

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module icache (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            fetch_req_i,
    input  logic            fetch_uncache_i,
    input  logic            flush_i,
    input  mem_pkg::bus32_t fetch_addr_i,
    output logic            fetch_ready_o,
    output logic            fetch_valid_o,
    output mem_pkg::bus32_t fetch_inst_o,
    cache_mem_if.cache      mem
);
    import mem_pkg::*;

    localparam int OFF_W  = $clog2(`LINE_WORDS * 4);
    localparam int WOFF_W = $clog2(`LINE_WORDS);
    localparam int IDX_W  = $clog2(`CACHE_LINES);
    localparam int TAG_W  = `ADDR_W - IDX_W - OFF_W;

    typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_REFILL, S_UNCACHED} state_e;

    state_e            state_q;
    state_e            state_d;
    bus32_t            addr_q;
    logic              uncache_q;
    logic              cancel_q;
    logic              accept;
    logic              hit;
    logic              answer;
    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [WOFF_W-1:0] woff;
    bus256_t           cur_line;

    logic [TAG_W-1:0]        tag_q  [`CACHE_LINES];
    bus256_t                 line_q [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;

    assign accept   = fetch_req_i && fetch_ready_o;
    assign idx      = addr_q[OFF_W +: IDX_W];
    assign tag      = addr_q[`ADDR_W-1 -: TAG_W];
    assign woff     = addr_q[2 +: WOFF_W];
    assign cur_line = line_q[idx];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:     if (accept) state_d = S_LOOKUP;
            S_LOOKUP: begin
                if (uncache_q) begin
                    state_d = S_UNCACHED;
                end else if (hit) begin
                    state_d = S_IDLE;
                end else begin
                    state_d = S_REFILL;
                end
            end
            // back to lookup, which then hits on the new line
            S_REFILL:   if (mem.ret_valid) state_d = S_LOOKUP;
            S_UNCACHED: if (mem.ucache_rvalid) state_d = S_IDLE;
            default:    state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q  <= S_IDLE;
            cancel_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                cancel_q <= 1'b0;
            end else if (flush_i && state_q != S_IDLE) begin
                cancel_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q    <= fetch_addr_i;
            uncache_q <= fetch_uncache_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (state_q == S_REFILL && mem.ret_valid) begin
            valid_q[idx] <= 1'b1;
        end
    end

    // refill completes even when the fetch was flushed
    always_ff @(posedge clk) begin
        if (state_q == S_REFILL && mem.ret_valid) begin
            line_q[idx] <= mem.ret_data;
            tag_q[idx]  <= tag;
        end
    end

    assign answer = (state_q == S_LOOKUP && !uncache_q && hit) ||
                    (state_q == S_UNCACHED && mem.ucache_rvalid);

    assign fetch_ready_o = (state_q == S_IDLE);
    assign fetch_valid_o = answer && !cancel_q && !flush_i;
    assign fetch_inst_o  = (state_q == S_UNCACHED) ? mem.ucache_rdata
                                                   : cur_line[woff*32 +: 32];

    assign mem.rd_req      = (state_q == S_LOOKUP) && !uncache_q && !hit;
    assign mem.rd_addr     = {addr_q[`ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign mem.ucache_ren  = (state_q == S_LOOKUP) && uncache_q;
    assign mem.ucache_addr = addr_q;

    // instruction side never writes
    assign mem.wr_en   = 1'b0;
    assign mem.wr_addr = '0;
    assign mem.wr_strb = '0;
    assign mem.wr_data = '0;

endmodule

// ==== verilog/inst_rom.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module inst_rom (
    input  logic     clk,
    input  logic     reset_i,
    cache_mem_if.mem mem
);
    import mem_pkg::*;

    bus256_t line_data;
    bus32_t  word_data;

    // line words from the image rule, wrapped to rom depth
    always_comb begin
        for (int k = 0; k < `LINE_WORDS; k++) begin
            line_data[k*32 +: 32] = rom_word(((mem.rd_addr >> 2) + k) % `MEM_WORDS);
        end
    end

    assign word_data = rom_word((mem.ucache_addr >> 2) % `MEM_WORDS);

    mem_delay_line #(
        .payload_t (bus256_t),
        .DEPTH     (`MEM_LATENCY)
    ) u_line_dl (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (mem.rd_req),
        .in_data_i   (line_data),
        .out_valid_o (mem.ret_valid),
        .out_data_o  (mem.ret_data)
    );

    mem_delay_line #(
        .payload_t (bus32_t),
        .DEPTH     (`MEM_LATENCY)
    ) u_word_dl (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (mem.ucache_ren),
        .in_data_i   (word_data),
        .out_valid_o (mem.ucache_rvalid),
        .out_data_o  (mem.ucache_rdata)
    );

    // read only
    assign mem.wr_ack = 1'b0;

endmodule

// ==== verilog/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// byte address width
`define ADDR_W 32

// 32-bit words per cache line
`define LINE_WORDS 8

// lines in each cache
`define CACHE_LINES 16

// words in the rom and in the ram
`define MEM_WORDS 1024

// cycles from request to return
`define MEM_LATENCY 3

`endif

// ==== verilog/mem_delay_line.sv ====
`timescale 1ns/1ns

module mem_delay_line #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    output payload_t out_data_o
);

    logic     valid_q [DEPTH];
    payload_t data_q  [DEPTH];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= in_valid_i;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // payload follows its valid stage by stage
    always_ff @(posedge clk) begin
        data_q[0] <= in_data_i;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid_o = valid_q[DEPTH-1];
    assign out_data_o  = data_q[DEPTH-1];

endmodule

// ==== verilog/mem_pkg.sv ====
`include "mem_cfg.svh"

package mem_pkg;

    typedef logic [31:0] bus32_t;

    // one cache line, word k at bits k*32
    typedef logic [`LINE_WORDS*32-1:0] bus256_t;

    typedef struct packed {
        logic   we;
        logic   uncache;
        bus32_t addr;
        logic [3:0] strb;
        bus32_t wdata;
    } lsu_req_t;

    // rom image word for a word index
    function automatic bus32_t rom_word(input bus32_t idx);
        bus32_t prod;
        prod = idx * 32'h9e3779b1;
        return prod ^ 32'h0badf00d;
    endfunction

endpackage

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ns

module mem_subsys_top (
    input  logic            clk,
    input  logic            reset_i,

    input  logic            fetch_req_i,
    input  mem_pkg::bus32_t fetch_addr_i,
    input  logic            fetch_uncache_i,
    input  logic            flush_i,
    output logic            fetch_ready_o,
    output logic            fetch_valid_o,
    output mem_pkg::bus32_t fetch_inst_o,

    input  logic            lsu_req_i,
    input  logic            lsu_we_i,
    input  logic            lsu_uncache_i,
    input  mem_pkg::bus32_t lsu_addr_i,
    input  logic [3:0]      lsu_strb_i,
    input  mem_pkg::bus32_t lsu_wdata_i,
    output logic            lsu_ready_o,
    output logic            lsu_valid_o,
    output mem_pkg::bus32_t lsu_rdata_o
);
    import mem_pkg::*;

    lsu_req_t lsu_req;

    cache_mem_if imem_io();
    cache_mem_if dmem_io();

    assign lsu_req.we      = lsu_we_i;
    assign lsu_req.uncache = lsu_uncache_i;
    assign lsu_req.addr    = lsu_addr_i;
    assign lsu_req.strb    = lsu_strb_i;
    assign lsu_req.wdata   = lsu_wdata_i;

    icache u_icache (
        .clk,
        .reset_i,
        .fetch_req_i,
        .fetch_uncache_i,
        .flush_i,
        .fetch_addr_i,
        .fetch_ready_o,
        .fetch_valid_o,
        .fetch_inst_o,
        .mem (imem_io.cache)
    );

    dcache u_dcache (
        .clk,
        .reset_i,
        .lsu_req_i,
        .lsu_req_data_i (lsu_req),
        .lsu_ready_o,
        .lsu_valid_o,
        .lsu_rdata_o,
        .mem            (dmem_io.cache)
    );

    inst_rom u_inst_rom (
        .clk,
        .reset_i,
        .mem (imem_io.mem)
    );

    data_ram u_data_ram (
        .clk,
        .reset_i,
        .mem (dmem_io.mem)
    );

endmodule
